/* build.f */
+incdir+include
logic/cache_pkg.sv
logic/mem_pkg.sv
logic/cache_way.sv
logic/cache_controller.sv
logic/banked_memory.sv
logic/mem_system.sv
tb/mem_system_tb.sv

/* Makefile */
TOP = mem_system_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* include/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: test name, byte address, then expected hit, read data and cycles
// from request to done (0 for a hit, 8 for a clean miss, 12 with writeback)
task automatic load_vectors();
	// Cold miss fills way 0 of index 2
	add_read("cold_read_miss", 16'h0012, 1'b0, initial_mem_word(16'h0012), 8);
	add_read("repeat_read_hit", 16'h0012, 1'b1, initial_mem_word(16'h0012), 0);
	add_write("write_hit", 16'h0014, 16'h1234, 1'b1, 0); // Line now dirty
	add_read("read_written", 16'h0014, 1'b1, 16'h1234, 0);
	add_read("read_word0", 16'h0010, 1'b1, initial_mem_word(16'h0010), 0);
	add_read("read_word3", 16'h0016, 1'b1, initial_mem_word(16'h0016), 0);

	// Store miss on index 0, replayed as a hit once the line is in
	add_write("write_miss", 16'h0300, 16'hBEEF, 1'b0, 8);
	add_read("read_write_miss", 16'h0300, 1'b1, 16'hBEEF, 0);
	add_read("read_fill_word", 16'h0302, 1'b1, initial_mem_word(16'h0302), 0);

	// Index 5 takes tags 00 and 01 in the two ways
	add_read("conflict_a", 16'h0028, 1'b0, initial_mem_word(16'h0028), 8);
	add_read("conflict_b", 16'h012A, 1'b0, initial_mem_word(16'h012A), 8);
	add_read("both_ways_a", 16'h0028, 1'b1, initial_mem_word(16'h0028), 0);
	add_read("both_ways_b", 16'h012A, 1'b1, initial_mem_word(16'h012A), 0);
	add_read("conflict_c", 16'h022C, 1'b0, initial_mem_word(16'h022C), 8); // Victim 0, bit flips
	add_read("evicted_a_miss", 16'h0028, 1'b0, initial_mem_word(16'h0028), 8); // Victim 1
	add_read("kept_c_hit", 16'h022C, 1'b1, initial_mem_word(16'h022C), 0);

	// Index 2 again, way 0 holds the dirty tag 00 and the victim bit is 0
	add_read("dirty_fill_b", 16'h0110, 1'b0, initial_mem_word(16'h0110), 8);
	add_read("dirty_evict", 16'h0210, 1'b0, initial_mem_word(16'h0210), 12);
	add_read("dirty_reread", 16'h0014, 1'b0, 16'h1234, 8); // Stored word back from memory
	add_read("dirty_reread_word", 16'h0016, 1'b1, initial_mem_word(16'h0016), 0);
	add_read("new_line_hit", 16'h0212, 1'b1, initial_mem_word(16'h0212), 0);

	// Odd addresses end at once with err
	add_odd("odd_read", 16'h0013, 1'b0);
	add_odd("odd_write", 16'h0101, 1'b1);
	add_read("after_odd_hit", 16'h0212, 1'b1, initial_mem_word(16'h0212), 0);
endtask

`endif

/* tb/mem_system_tb.sv */
`timescale 1ns/1ps

module mem_system_tb import cache_pkg::*; ();

	localparam int MEM_DEPTH_WORDS = 4096;
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2; // After the rising edge
	localparam int TIMEOUT_CYCLES = 20;

	typedef struct packed {
		cpu_req_t req;
		cpu_rsp_t exp; // rdata, hit and err are compared
		logic chk_data; // Writes and rejected accesses return no data
		int exp_cycles; // Request cycle to done
	} vector_t;

	logic clk;
	logic reset;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;

	vector_t vectors[$];
	string names[$];
	int num_tests;
	int num_failed;

	mem_system #(
		.MEM_DEPTH_WORDS(MEM_DEPTH_WORDS)
	) u_mem_system (
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Power-up memory contents, depth wraps on the byte address
	function automatic logic [DATA_BITS-1:0] initial_mem_word(
			input logic [ADDR_BITS-1:0] addr);
		logic [ADDR_BITS-1:0] wrapped;
		wrapped = addr & ADDR_BITS'(MEM_DEPTH_WORDS * 2 - 1);
		return wrapped ^ 16'hA5A5;
	endfunction

	task automatic add_vector(input string name, input logic rd, input logic wr,
			input logic [ADDR_BITS-1:0] addr, input logic [DATA_BITS-1:0] wdata,
			input logic exp_hit, input logic exp_err, input logic chk_data,
			input logic [DATA_BITS-1:0] exp_rdata, input int exp_cycles);
		vector_t v;
		v.req.addr.raw = addr;
		v.req.wdata = wdata;
		v.req.rd = rd;
		v.req.wr = wr;
		v.exp.rdata = exp_rdata;
		v.exp.done = 1'b1;
		v.exp.stall = 1'b0;
		v.exp.hit = exp_hit;
		v.exp.err = exp_err;
		v.chk_data = chk_data;
		v.exp_cycles = exp_cycles;
		vectors.push_back(v);
		names.push_back(name);
	endtask

	task automatic add_read(input string name, input logic [ADDR_BITS-1:0] addr,
			input logic exp_hit, input logic [DATA_BITS-1:0] exp_rdata, input int exp_cycles);
		add_vector(name, 1'b1, 1'b0, addr, '0, exp_hit, 1'b0, 1'b1, exp_rdata, exp_cycles);
	endtask

	task automatic add_write(input string name, input logic [ADDR_BITS-1:0] addr,
			input logic [DATA_BITS-1:0] wdata, input logic exp_hit, input int exp_cycles);
		add_vector(name, 1'b0, 1'b1, addr, wdata, exp_hit, 1'b0, 1'b0, '0, exp_cycles);
	endtask

	task automatic add_odd(input string name, input logic [ADDR_BITS-1:0] addr, input logic wr);
		add_vector(name, ~wr, wr, addr, 16'h5A5A, 1'b0, 1'b1, 1'b0, '0, 0);
	endtask

	`include "tb_vectors.svh"

	task automatic check_rsp(input string name, input cpu_rsp_t exp, input cpu_rsp_t act,
			input logic chk_data, output logic ok);
		logic data_ok;
		data_ok = !chk_data || (act.rdata === exp.rdata);
		ok = data_ok && (act.hit === exp.hit) && (act.err === exp.err);
		if (!ok) begin
			$display("FAIL %s: expected rdata=%h hit=%b err=%b, actual rdata=%h hit=%b err=%b",
				name, exp.rdata, exp.hit, exp.err, act.rdata, act.hit, act.err);
		end
	endtask

	task automatic check_latency(input string name, input int exp_cycles, input int act_cycles,
			output logic ok);
		ok = (act_cycles == exp_cycles);
		if (!ok) begin
			$display("FAIL %s: expected cycles=%0d, actual cycles=%0d",
				name, exp_cycles, act_cycles);
		end
	endtask

	// Stall is high from the request cycle up to done
	task automatic check_stall(input string name, input int exp_cycles, input int act_cycles,
			output logic ok);
		ok = (act_cycles == exp_cycles);
		if (!ok) begin
			$display("FAIL %s: expected stall cycles=%0d, actual stall cycles=%0d",
				name, exp_cycles, act_cycles);
		end
	endtask

	task automatic check_idle(input string name, input cpu_rsp_t act, output logic ok);
		ok = (act.done === 1'b0) && (act.stall === 1'b0);
		if (!ok) begin
			$display("FAIL %s: expected done=0 stall=0, actual done=%b stall=%b",
				name, act.done, act.stall);
		end
	endtask

	task automatic report_pass(input string name, input cpu_rsp_t exp, input cpu_rsp_t act,
			input int exp_cycles, input int act_cycles);
		$display("PASS %s: expected hit=%b err=%b cycles=%0d, actual hit=%b err=%b cycles=%0d",
			name, exp.hit, exp.err, exp_cycles, act.hit, act.err, act_cycles);
	endtask

	initial begin
		int cycles;
		int stall_cycles;
		logic rsp_ok;
		logic lat_ok;
		logic stall_ok;
		logic timed_out;
		cpu_rsp_t rsp;

		cpu_req = '0;
		reset = 1'b1;
		num_tests = 0;
		num_failed = 0;
		timed_out = 1'b0;
		load_vectors();
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		@(negedge clk); // Idle outputs before any request
		num_tests++;
		check_idle("reset_idle", cpu_rsp, rsp_ok);
		if (rsp_ok) begin
			$display("PASS reset_idle: expected done=0 stall=0, actual done=%b stall=%b",
				cpu_rsp.done, cpu_rsp.stall);
		end else begin
			num_failed++;
		end

		for (int i = 0; i < vectors.size() && !timed_out; i++) begin
			@(posedge clk);
			#DRIVE_DELAY;
			cpu_req = vectors[i].req; // Held until done
			cycles = 0;
			stall_cycles = 0;
			@(negedge clk);
			while (!cpu_rsp.done && cycles < TIMEOUT_CYCLES) begin
				if (cpu_rsp.stall === 1'b1) begin
					stall_cycles++;
				end
				@(negedge clk);
				cycles++;
			end
			rsp = cpu_rsp;
			num_tests++;
			if (!rsp.done) begin
				$display("ERROR %s: no done within %0d cycles", names[i], TIMEOUT_CYCLES);
				num_failed++;
				timed_out = 1'b1; // Cache state unknown from here on
			end else begin
				check_rsp(names[i], vectors[i].exp, rsp, vectors[i].chk_data, rsp_ok);
				check_latency(names[i], vectors[i].exp_cycles, cycles, lat_ok);
				check_stall(names[i], vectors[i].exp_cycles, stall_cycles, stall_ok);
				if (rsp_ok && lat_ok && stall_ok) begin
					report_pass(names[i], vectors[i].exp, rsp, vectors[i].exp_cycles, cycles);
				end else begin
					num_failed++;
				end
			end
			@(posedge clk);
			#DRIVE_DELAY;
			cpu_req = '0; // One idle cycle between accesses
		end

		$display("Tests: %0d, passed: %0d, failed: %0d",
			num_tests, num_tests - num_failed, num_failed);
		if (num_failed == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* logic/mem_system.sv */
`timescale 1ns/1ps

module mem_system import cache_pkg::*, mem_pkg::*; #(
	parameter int MEM_DEPTH_WORDS = 4096
) (
	input logic clk,
	input logic reset,
	input cpu_req_t cpu_req,
	output cpu_rsp_t cpu_rsp
);

	way_ctrl_t way0_ctrl;
	way_ctrl_t way1_ctrl;
	way_status_t way0_status;
	way_status_t way1_status;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	cache_controller u_cache_controller (
		.clk(clk),
		.reset(reset),
		.cpu_req(cpu_req),
		.cpu_rsp(cpu_rsp),
		.way0_status(way0_status),
		.way1_status(way1_status),
		.way0_ctrl(way0_ctrl),
		.way1_ctrl(way1_ctrl),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

	cache_way u_way0 (
		.clk(clk),
		.reset(reset),
		.ctrl(way0_ctrl),
		.status(way0_status)
	);

	cache_way u_way1 (
		.clk(clk),
		.reset(reset),
		.ctrl(way1_ctrl),
		.status(way1_status)
	);

	banked_memory #(
		.MEM_DEPTH_WORDS(MEM_DEPTH_WORDS)
	) u_banked_memory (
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.mem_rsp(mem_rsp)
	);

endmodule

/* logic/banked_memory.sv */
`timescale 1ns/1ps

module banked_memory import mem_pkg::*; #(
	parameter int MEM_DEPTH_WORDS = 4096
) (
	input logic clk,
	input logic reset,
	input mem_req_t mem_req,
	output mem_rsp_t mem_rsp
);

	localparam int BANK_BITS = $clog2(NUM_BANKS);
	localparam int BANK_DEPTH = MEM_DEPTH_WORDS / NUM_BANKS;
	localparam int ROW_BITS = $clog2(BANK_DEPTH);

	logic [MEM_DATA_BITS-1:0] bank_mem [NUM_BANKS][BANK_DEPTH];
	logic [BANK_BITS-1:0] bank;
	logic [ROW_BITS-1:0] row;
	logic [MEM_LATENCY-2:0] rd_valid_q;
	logic [BANK_BITS-1:0] rd_bank_q [MEM_LATENCY-1];
	logic [ROW_BITS-1:0] rd_row_q [MEM_LATENCY-1];
	logic [MEM_DATA_BITS-1:0] rd_data_q;
	logic last_active_q;
	logic [BANK_BITS-1:0] last_bank_q;

	assign bank = mem_req.addr[BANK_BITS:1]; // Consecutive words in consecutive banks
	assign row = mem_req.addr[ROW_BITS+BANK_BITS:BANK_BITS+1]; // Upper bits wrap

	assign mem_rsp.rdata = rd_data_q;
	assign mem_rsp.err = (mem_req.rd | mem_req.wr) & last_active_q & (bank == last_bank_q);

	// Preload each word with its byte address XOR A5A5
	initial begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			for (int r = 0; r < BANK_DEPTH; r++) begin
				bank_mem[b][r] = MEM_DATA_BITS'((r * NUM_BANKS + b) * 2) ^ 16'hA5A5;
			end
		end
	end

	always @(posedge clk) begin
		if (mem_req.wr) begin
			bank_mem[bank][row] <= mem_req.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid_q <= '0;
			last_active_q <= 1'b0;
		end else begin
			rd_valid_q[0] <= mem_req.rd;
			for (int i = 1; i < MEM_LATENCY - 1; i++) begin
				rd_valid_q[i] <= rd_valid_q[i-1];
			end
			last_active_q <= mem_req.rd | mem_req.wr;
		end
	end

	// Address stages, then the bank read into the output register
	always_ff @(posedge clk) begin
		rd_bank_q[0] <= bank;
		rd_row_q[0] <= row;
		for (int i = 1; i < MEM_LATENCY - 1; i++) begin
			rd_bank_q[i] <= rd_bank_q[i-1];
			rd_row_q[i] <= rd_row_q[i-1];
		end
		last_bank_q <= bank;
		if (rd_valid_q[MEM_LATENCY-2]) begin
			rd_data_q <= bank_mem[rd_bank_q[MEM_LATENCY-2]][rd_row_q[MEM_LATENCY-2]];
		end
	end

	a_mem_rd_wr: assert property (@(posedge clk) disable iff (reset)
		!(mem_req.rd && mem_req.wr));

endmodule

/* logic/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller import cache_pkg::*, mem_pkg::*; (
	input logic clk,
	input logic reset,
	input cpu_req_t cpu_req,
	output cpu_rsp_t cpu_rsp,
	input way_status_t way0_status,
	input way_status_t way1_status,
	output way_ctrl_t way0_ctrl,
	output way_ctrl_t way1_ctrl,
	output mem_req_t mem_req,
	input mem_rsp_t mem_rsp
);

	typedef enum logic [3:0] {
		st_idle, st_enable,
		st_wb0, st_wb1, st_wb2, st_wb3,
		st_req0, st_req1, st_req2_wr0, st_req3_wr1,
		st_wr2, st_wr3, st_done
	} state_e;

	state_e state_q;
	state_e state_d;
	cache_addr_u req_addr_q;
	logic [DATA_BITS-1:0] req_wdata_q;
	logic req_wr_q;
	logic victim_q; // Round-robin bit
	logic victim_d;
	logic victim_sel_q; // Way being replaced
	logic victim_sel_d;
	way_ctrl_t ctrl_c;
	logic [1:0] way_mask;
	way_status_t victim_status;
	cache_addr_u mem_addr;
	logic wb_step;
	logic req_active;
	logic req_odd;
	logic any_hit;

	// Word of the line handled by the cache side in each step
	function automatic logic [OFFSET_BITS-1:0] way_step_offset(input state_e st);
		case (st)
			st_wb1, st_req3_wr1: return 3'b010;
			st_wb2, st_wr2: return 3'b100;
			st_wb3, st_wr3: return 3'b110;
			default: return 3'b000;
		endcase
	endfunction

	// Word of the line on the memory bus in each step
	function automatic logic [OFFSET_BITS-1:0] mem_step_offset(input state_e st);
		case (st)
			st_wb1, st_req1: return 3'b010;
			st_wb2, st_req2_wr0: return 3'b100;
			st_wb3, st_req3_wr1: return 3'b110;
			default: return 3'b000;
		endcase
	endfunction

	assign req_active = cpu_req.rd | cpu_req.wr;
	assign req_odd = cpu_req.addr.f.offset[0];
	assign any_hit = way0_status.hit | way1_status.hit;
	assign victim_status = victim_sel_q ? way1_status : way0_status;
	assign wb_step = state_q inside {st_wb0, st_wb1, st_wb2, st_wb3};

	// Way control depends only on state and latched request
	always_comb begin
		ctrl_c.enable = 1'b0;
		ctrl_c.comp = 1'b0;
		ctrl_c.write = 1'b0;
		ctrl_c.index = req_addr_q.f.index;
		ctrl_c.offset = req_addr_q.f.offset;
		ctrl_c.tag_in = req_addr_q.f.tag;
		ctrl_c.wdata = mem_rsp.rdata; // Fill data straight from memory
		way_mask = victim_sel_q ? 2'b10 : 2'b01;
		case (state_q)
			st_idle: begin
				ctrl_c.enable = req_active & ~req_odd;
				ctrl_c.comp = 1'b1;
				ctrl_c.write = cpu_req.wr;
				ctrl_c.index = cpu_req.addr.f.index;
				ctrl_c.offset = cpu_req.addr.f.offset;
				ctrl_c.tag_in = cpu_req.addr.f.tag;
				ctrl_c.wdata = cpu_req.wdata;
				way_mask = 2'b11;
			end
			st_enable: begin
				ctrl_c.enable = 1'b1; // Read valid and dirty of both ways
				way_mask = 2'b11;
			end
			st_wb0, st_wb1, st_wb2, st_wb3: begin
				ctrl_c.enable = 1'b1;
				ctrl_c.offset = way_step_offset(state_q);
			end
			st_req2_wr0, st_req3_wr1, st_wr2, st_wr3: begin
				ctrl_c.enable = 1'b1;
				ctrl_c.write = 1'b1; // Lags its request by MEM_LATENCY
				ctrl_c.offset = way_step_offset(state_q);
			end
			st_done: begin
				ctrl_c.enable = 1'b1;
				ctrl_c.comp = 1'b1; // Replay the access, now a hit
				ctrl_c.write = req_wr_q;
				ctrl_c.wdata = req_wdata_q;
				way_mask = 2'b11;
			end
			default: way_mask = 2'b00;
		endcase
	end

	always_comb begin
		way0_ctrl = ctrl_c;
		way1_ctrl = ctrl_c;
		way0_ctrl.enable = ctrl_c.enable & way_mask[0];
		way1_ctrl.enable = ctrl_c.enable & way_mask[1];
	end

	always_comb begin
		state_d = state_q;
		victim_d = victim_q;
		victim_sel_d = victim_sel_q;
		mem_addr.f.tag = wb_step ? victim_status.tag_out : req_addr_q.f.tag;
		mem_addr.f.index = req_addr_q.f.index;
		mem_addr.f.offset = mem_step_offset(state_q);
		mem_req.addr = mem_addr.raw;
		mem_req.wdata = victim_status.rdata;
		mem_req.wr = wb_step;
		mem_req.rd = state_q inside {st_req0, st_req1, st_req2_wr0, st_req3_wr1};
		cpu_rsp.rdata = way1_status.hit ? way1_status.rdata : way0_status.rdata;
		cpu_rsp.done = 1'b0;
		cpu_rsp.stall = 1'b1;
		cpu_rsp.hit = 1'b0;
		cpu_rsp.err = mem_rsp.err;
		case (state_q)
			st_idle: begin
				cpu_rsp.stall = 1'b0;
				if (req_active && req_odd) begin
					cpu_rsp.done = 1'b1; // Rejected at once
					cpu_rsp.err = 1'b1;
				end else if (req_active) begin
					cpu_rsp.done = any_hit;
					cpu_rsp.hit = any_hit;
					cpu_rsp.stall = ~any_hit;
					state_d = any_hit ? st_idle : st_enable;
				end
			end
			st_enable: begin
				if (!way0_status.valid) begin
					victim_sel_d = 1'b0; // Empty way first
				end else if (!way1_status.valid) begin
					victim_sel_d = 1'b1;
				end else begin
					victim_sel_d = victim_q;
					victim_d = ~victim_q;
				end
				if (victim_sel_d ? (way1_status.valid & way1_status.dirty)
						: (way0_status.valid & way0_status.dirty)) begin
					state_d = st_wb0;
				end else begin
					state_d = st_req0;
				end
			end
			st_wb0: state_d = st_wb1;
			st_wb1: state_d = st_wb2;
			st_wb2: state_d = st_wb3;
			st_wb3: state_d = st_req0;
			st_req0: state_d = st_req1;
			st_req1: state_d = st_req2_wr0;
			st_req2_wr0: state_d = st_req3_wr1;
			st_req3_wr1: state_d = st_wr2;
			st_wr2: state_d = st_wr3;
			st_wr3: state_d = st_done;
			st_done: begin
				cpu_rsp.done = 1'b1;
				cpu_rsp.stall = 1'b0;
				state_d = st_idle;
			end
			default: begin
				cpu_rsp.err = 1'b1; // Illegal state
				state_d = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= st_idle;
			victim_q <= 1'b0;
			victim_sel_q <= 1'b0;
		end else begin
			state_q <= state_d;
			victim_q <= victim_d;
			victim_sel_q <= victim_sel_d;
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == st_idle) begin
			req_addr_q <= cpu_req.addr; // Frozen for the whole miss
			req_wdata_q <= cpu_req.wdata;
			req_wr_q <= cpu_req.wr;
		end
	end

	a_cpu_rd_wr: assert property (@(posedge clk) disable iff (reset)
		!(cpu_req.rd && cpu_req.wr));

	// A stall runs until done and never overlaps it
	a_stall_done: assert property (@(posedge clk) disable iff (reset)
		!(cpu_rsp.stall && cpu_rsp.done)
		&& (!$past(cpu_rsp.stall) || cpu_rsp.stall || cpu_rsp.done));

endmodule

/* logic/cache_way.sv */
`timescale 1ns/1ps

module cache_way import cache_pkg::*; (
	input logic clk,
	input logic reset,
	input way_ctrl_t ctrl,
	output way_status_t status
);

	logic [TAG_BITS-1:0] tag_mem [NUM_LINES];
	logic [DATA_BITS-1:0] data_mem [NUM_LINES][WORDS_PER_LINE];
	logic [NUM_LINES-1:0] valid_q;
	logic [NUM_LINES-1:0] dirty_q;
	logic [OFFSET_BITS-2:0] word;
	logic line_valid;
	logic tag_match;
	logic way_hit;
	logic fill_wr;
	logic hit_wr;

	assign word = ctrl.offset[OFFSET_BITS-1:1]; // Drop byte bit
	assign line_valid = valid_q[ctrl.index];
	assign tag_match = (tag_mem[ctrl.index] == ctrl.tag_in);
	assign way_hit = ctrl.enable & ctrl.comp & line_valid & tag_match;

	assign fill_wr = ctrl.enable & ctrl.write & ~ctrl.comp; // Line fill from memory
	assign hit_wr = ctrl.write & way_hit; // Processor store

	// Lookup is asynchronous so a hit resolves in the request cycle
	always_comb begin
		status.hit = way_hit;
		status.valid = line_valid;
		status.dirty = dirty_q[ctrl.index];
		status.tag_out = tag_mem[ctrl.index];
		status.rdata = data_mem[ctrl.index][word];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else if (fill_wr) begin
			valid_q[ctrl.index] <= 1'b1;
			dirty_q[ctrl.index] <= 1'b0; // Fresh copy of memory
		end else if (hit_wr) begin
			dirty_q[ctrl.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_wr || hit_wr) begin
			data_mem[ctrl.index][word] <= ctrl.wdata;
		end
		if (fill_wr) begin
			tag_mem[ctrl.index] <= ctrl.tag_in;
		end
	end

	// The controller filters odd addresses before any way sees them
	a_even_offset: assert property (@(posedge clk) disable iff (reset)
		ctrl.enable |-> !ctrl.offset[0]);

endmodule

/* logic/mem_pkg.sv */
package mem_pkg;

	localparam int MEM_LATENCY = 2; // Read strobe to data, in cycles
	localparam int MEM_ADDR_BITS = 16;
	localparam int MEM_DATA_BITS = 16;
	localparam int NUM_BANKS = 4;

	typedef struct packed {
		logic [MEM_ADDR_BITS-1:0] addr; // Byte address
		logic [MEM_DATA_BITS-1:0] wdata;
		logic rd; // Single-cycle strobes
		logic wr;
	} mem_req_t;

	typedef struct packed {
		logic [MEM_DATA_BITS-1:0] rdata;
		logic err; // Bank hit twice in a row
	} mem_rsp_t;

endpackage

/* logic/cache_pkg.sv */
package cache_pkg;

	localparam int TAG_BITS = 8;
	localparam int INDEX_BITS = 5;
	localparam int OFFSET_BITS = 3;
	localparam int ADDR_BITS = TAG_BITS + INDEX_BITS + OFFSET_BITS;
	localparam int DATA_BITS = 16;
	localparam int NUM_LINES = 2 ** INDEX_BITS;
	localparam int WORDS_PER_LINE = 4;

	typedef struct packed {
		logic [TAG_BITS-1:0] tag;
		logic [INDEX_BITS-1:0] index;
		logic [OFFSET_BITS-1:0] offset; // Byte offset, bit 0 must be clear
	} cache_addr_s;

	// Same word seen as a flat bus address or as cache fields
	typedef union packed {
		logic [ADDR_BITS-1:0] raw;
		cache_addr_s f;
	} cache_addr_u;

	typedef struct packed {
		cache_addr_u addr;
		logic [DATA_BITS-1:0] wdata;
		logic rd; // Level, held until done
		logic wr;
	} cpu_req_t;

	typedef struct packed {
		logic [DATA_BITS-1:0] rdata;
		logic done;
		logic stall;
		logic hit;
		logic err;
	} cpu_rsp_t;

	typedef struct packed {
		logic enable;
		logic comp; // Compare mode, else access mode
		logic write;
		logic [INDEX_BITS-1:0] index;
		logic [OFFSET_BITS-1:0] offset;
		logic [TAG_BITS-1:0] tag_in;
		logic [DATA_BITS-1:0] wdata;
	} way_ctrl_t;

	typedef struct packed {
		logic hit;
		logic valid;
		logic dirty;
		logic [TAG_BITS-1:0] tag_out;
		logic [DATA_BITS-1:0] rdata;
	} way_status_t;

endpackage
